// ==== hw/tx_resp_pkg.sv ====
//######################################
// Transmit responder shared types,
// settings addresses and sizes.
//######################################
`default_nettype none

package tx_resp_pkg;

   // Message class, top two bits of pkt_type.
   typedef enum logic [1:0] {
      MSG_FC  = 2'b01,   // Flow control or end-of-burst ack.
      MSG_ERR = 2'b11
   } resp_msg_e;

   // One pending response.
   typedef struct packed {
      logic [3:0]  pkt_type;   // {class, has_time, eob}.
      logic [31:0] sid;        // Halves already swapped.
      logic [63:0] body;
   } resp_msg_t;

   // Strobe settings bus.
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // Flow control settings registers.
   localparam logic [7:0] SR_FC_CYCS_ADDR = 8'd0;
   localparam logic [7:0] SR_FC_PKTS_ADDR = 8'd1;

   localparam int SR_THR_W = 31;   // Threshold field, enable above it.

   // Response queue.
   localparam int MSG_FIFO_DEPTH = 16;
   localparam int MSG_PTR_W      = $clog2(MSG_FIFO_DEPTH);

   localparam int USE_TIME_DEFAULT = 1;

   // Bytes per context packet word.
   localparam int CTX_HDR_BYTES = 8;

endpackage

`default_nettype wire

// ==== hw/fc_ack_trigger.sv ====
//######################################
// Flow control ack trigger. Counts
// packets and cycles against settings.
//######################################
`timescale 1ns/1ps
`default_nettype none

module fc_ack_trigger (
   input  logic                  clk,
   input  logic                  i_rst_n,
   input  tx_resp_pkg::set_bus_t i_set,
   input  logic                  i_packet_consumed,
   output logic                  o_trigger
);
   import tx_resp_pkg::*;

   logic                cycs_en;
   logic [SR_THR_W-1:0] cycs_thr;
   logic                pkts_en;
   logic [SR_THR_W-1:0] pkts_thr;

   logic [SR_THR_W-1:0] pkt_cnt;
   logic [SR_THR_W-1:0] cyc_cnt;
   logic                pkt_seen;

   logic [SR_THR_W-1:0] pkt_cnt_nxt;
   logic [SR_THR_W-1:0] cyc_cnt_nxt;
   logic                active;
   logic                fire_pkts;
   logic                fire_cycs;
   logic                fire;

   always_ff @(posedge clk)
   begin
      if (!i_rst_n)
      begin
         cycs_en  <= 1'b0;
         cycs_thr <= '0;
         pkts_en  <= 1'b0;
         pkts_thr <= '0;
      end
      else if (i_set.stb)
      begin
         if (i_set.addr == SR_FC_CYCS_ADDR)
         begin
            cycs_en  <= i_set.data[31];
            cycs_thr <= i_set.data[SR_THR_W-1:0];
         end
         if (i_set.addr == SR_FC_PKTS_ADDR)
         begin
            pkts_en  <= i_set.data[31];
            pkts_thr <= i_set.data[SR_THR_W-1:0];
         end
      end
   end

   // Cycles count only once a packet has gone by.
   assign active      = pkt_seen | i_packet_consumed;
   assign pkt_cnt_nxt = pkt_cnt + SR_THR_W'(i_packet_consumed);
   assign cyc_cnt_nxt = cyc_cnt + SR_THR_W'(active);

   assign fire_pkts = pkts_en & i_packet_consumed & (pkt_cnt_nxt >= pkts_thr);
   assign fire_cycs = cycs_en & active & (cyc_cnt_nxt >= cycs_thr);
   assign fire      = fire_pkts | fire_cycs;

   always_ff @(posedge clk)
   begin
      if (!i_rst_n || fire)
      begin
         pkt_cnt  <= '0;
         cyc_cnt  <= '0;
         pkt_seen <= 1'b0;
      end
      else
      begin
         pkt_cnt  <= pkt_cnt_nxt;
         cyc_cnt  <= cyc_cnt_nxt;
         pkt_seen <= active;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!i_rst_n)
         o_trigger <= 1'b0;
      else
         o_trigger <= fire;
   end

   a_trig_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_trigger |=> !o_trigger);

endmodule

`default_nettype wire

// ==== hw/resp_msg_fifo.sv ====
//######################################
// Queue of pending response messages.
//######################################
`timescale 1ns/1ps
`default_nettype none

module resp_msg_fifo (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  tx_resp_pkg::resp_msg_t i_msg,
   input  logic                   i_push,
   output tx_resp_pkg::resp_msg_t o_msg,
   output logic                   o_valid,
   input  logic                   i_pop
);
   import tx_resp_pkg::*;

   resp_msg_t            mem [MSG_FIFO_DEPTH];
   logic [MSG_PTR_W-1:0] wr_ptr;
   logic [MSG_PTR_W-1:0] rd_ptr;
   logic [MSG_PTR_W:0]   count;
   logic                 full;
   logic                 wr_en;
   logic                 rd_en;

   assign full    = (count == (MSG_PTR_W + 1)'(MSG_FIFO_DEPTH));
   assign o_valid = (count != '0);
   assign o_msg   = mem[rd_ptr];   // Head, read straight from storage.
   assign wr_en   = i_push & ~full;
   assign rd_en   = i_pop & o_valid;

   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_ptr] <= i_msg;
   end

   always_ff @(posedge clk)
   begin
      if (!i_rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;   // Depth is a power of two.
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         if (wr_en && !rd_en)
            count <= count + 1'b1;
         else if (rd_en && !wr_en)
            count <= count - 1'b1;
      end
   end

   // Events arriving on a full queue would be lost.
   a_no_overflow: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(i_push && full));

   a_no_underflow: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(i_pop && !o_valid));

endmodule

`default_nettype wire

// ==== hw/context_pkt_gen.sv ====
//######################################
// Context packet generator. Header,
// optional time and body on AXI-Stream.
//######################################
`timescale 1ns/1ps
`default_nettype none

module context_pkt_gen #(
   parameter int USE_TIME = tx_resp_pkg::USE_TIME_DEFAULT
) (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  tx_resp_pkg::resp_msg_t i_msg,
   input  logic                   i_valid,
   output logic                   o_done,
   input  logic [63:0]            i_vita_time,
   output logic [63:0]            o_tdata,
   output logic                   o_tlast,
   output logic                   o_tvalid,
   input  logic                   i_tready
);
   import tx_resp_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_HDR,
      ST_TIME,
      ST_BODY
   } state_e;

   localparam int          NUM_WORDS = (USE_TIME != 0) ? 3 : 2;
   localparam logic [15:0] PKT_LEN   = 16'(NUM_WORDS * CTX_HDR_BYTES);

   state_e      state;
   logic [11:0] seq_q;    // Reply sequence number.
   logic [63:0] time_q;
   logic        xfer;

   assign o_tvalid = (state != ST_IDLE);
   assign o_tlast  = (state == ST_BODY);
   assign xfer     = o_tvalid & i_tready;
   assign o_done   = xfer & o_tlast;   // Pops the queue head.

   always_comb
   begin
      case (state)
         ST_TIME: o_tdata = time_q;
         ST_BODY: o_tdata = i_msg.body;
         default: o_tdata = {i_msg.pkt_type, seq_q, PKT_LEN, i_msg.sid};
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!i_rst_n)
         state <= ST_IDLE;
      else
      begin
         case (state)
            ST_IDLE:
               if (i_valid)
                  state <= ST_HDR;
            ST_HDR:
               if (i_tready)
                  state <= (USE_TIME != 0) ? ST_TIME : ST_BODY;
            ST_TIME:
               if (i_tready)
                  state <= ST_BODY;
            default:
               if (i_tready)
                  state <= ST_IDLE;
         endcase
      end
   end

   // Time as seen when the header goes out.
   always_ff @(posedge clk)
   begin
      if (xfer && state == ST_HDR)
         time_q <= i_vita_time;
   end

   always_ff @(posedge clk)
   begin
      if (!i_rst_n)
         seq_q <= '0;
      else if (o_done)
         seq_q <= seq_q + 1'b1;   // Wraps at 12 bits.
   end

   a_stall_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
      (o_tvalid && !i_tready) |=> (o_tvalid && $stable(o_tdata) && $stable(o_tlast)));

endmodule

`default_nettype wire

// ==== hw/tx_responder.sv ====
//######################################
// Transmit responder top. Builds ack and
// error messages, queues and sends them.
//######################################
`timescale 1ns/1ps
`default_nettype none

module tx_responder #(
   parameter int USE_TIME = tx_resp_pkg::USE_TIME_DEFAULT
) (
   input  logic                  clk,
   input  logic                  i_rst_n,
   input  tx_resp_pkg::set_bus_t i_set,
   input  logic                  i_ack,
   input  logic                  i_error,
   input  logic                  i_packet_consumed,
   input  logic [11:0]           i_seqnum,
   input  logic [63:0]           i_error_code,
   input  logic [31:0]           i_sid,
   input  logic [63:0]           i_vita_time,
   output logic [63:0]           o_tdata,
   output logic                  o_tlast,
   output logic                  o_tvalid,
   input  logic                  i_tready
);
   import tx_resp_pkg::*;

   logic [31:0] seq_ext;    // Extended sequence number.
   logic        fc_trigger;
   logic        eob;
   logic        has_time;
   logic        push;
   resp_msg_e   msg_class;
   resp_msg_t   push_msg;
   resp_msg_t   head_msg;
   logic        head_valid;
   logic        head_done;

   // Low bits follow the input, upper bits count wraps.
   always_ff @(posedge clk)
   begin
      if (!i_rst_n)
         seq_ext <= '0;
      else if (i_packet_consumed)
      begin
         if (seq_ext[11:0] == 12'hFFF)
            seq_ext[31:12] <= seq_ext[31:12] + 1'b1;
         seq_ext[11:0] <= i_seqnum;
      end
   end

   assign eob       = i_ack | i_error;
   assign has_time  = (USE_TIME != 0);
   assign msg_class = i_error ? MSG_ERR : MSG_FC;
   assign push      = eob | fc_trigger;   // Coincident events make one message.

   always_comb
   begin
      push_msg.pkt_type = {msg_class, has_time, eob};
      push_msg.sid      = {i_sid[15:0], i_sid[31:16]};
      push_msg.body     = eob ? i_error_code : {32'd0, seq_ext};
   end

   fc_ack_trigger u_trig (
      .clk               (clk),
      .i_rst_n           (i_rst_n),
      .i_set             (i_set),
      .i_packet_consumed (i_packet_consumed),
      .o_trigger         (fc_trigger)
   );

   resp_msg_fifo u_queue (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_msg   (push_msg),
      .i_push  (push),
      .o_msg   (head_msg),
      .o_valid (head_valid),
      .i_pop   (head_done)
   );

   context_pkt_gen #(.USE_TIME(USE_TIME)) u_gen (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_msg       (head_msg),
      .i_valid     (head_valid),
      .o_done      (head_done),
      .i_vita_time (i_vita_time),
      .o_tdata     (o_tdata),
      .o_tlast     (o_tlast),
      .o_tvalid    (o_tvalid),
      .i_tready    (i_tready)
   );

endmodule

`default_nettype wire

// ==== verif/tb_tx_responder.sv ====
//######################################
// Transmit responder testbench. Checks
// output packets against a model queue.
//######################################
`timescale 1ns/1ps
`default_nettype none

module tb_tx_responder;
   import tx_resp_pkg::*;

   localparam int          RESET_CYCLES = 10;
   localparam int          NUM_EVENTS   = 17;
   localparam int          FC_PKTS      = 4;
   localparam int          LAST_IDX     = 2;   // Header, time, body.
   localparam logic [15:0] PKT_LEN      = 16'((LAST_IDX + 1) * CTX_HDR_BYTES);

   logic        clk               = 1'b0;
   logic        i_rst_n           = 1'b0;
   set_bus_t    i_set             = '0;
   logic        i_ack             = 1'b0;
   logic        i_error           = 1'b0;
   logic        i_packet_consumed = 1'b0;
   logic [11:0] i_seqnum          = '0;
   logic [63:0] i_error_code      = '0;
   logic [31:0] i_sid             = '0;
   logic [63:0] i_vita_time       = '0;
   logic        i_tready          = 1'b1;
   logic [63:0] o_tdata;
   logic        o_tlast;
   logic        o_tvalid;

   logic [31:0] lfsr       = 32'h4dd7_c8dc;
   logic        rand_ready = 1'b0;
   logic [31:0] seq_model  = '0;   // Extended sequence number.
   int          pkt_cnt    = 0;
   resp_msg_t   exp_mem [NUM_EVENTS + 1];
   int          wr_idx     = 0;
   int          rd_idx     = 0;
   int          word_idx   = 0;
   logic [11:0] exp_rseq   = '0;
   logic [63:0] exp_time   = '0;
   logic [63:0] exp_word;
   logic        stall_q    = 1'b0;
   logic [63:0] held_tdata = '0;

   tx_responder i_dut (.*);

   always #10 clk = ~clk;

   always @(negedge clk)
      i_vita_time <= i_vita_time + 64'd1;   // Free-running time.

   // Galois LFSR, one step per bit.
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] val;
      logic        b;
      int          i;
      val = '0;
      for (i = 0; i < n; i++)
      begin
         b    = lfsr[0];
         lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
         val  = {val[62:0], b};
      end
      return val;
   endfunction

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic next_cycle();
      @(negedge clk);
      if (rand_ready)
         i_tready = (rand_bits(2) != '0);   // Ready three cycles in four.
   endtask

   task automatic expect_msg(input resp_msg_e cls, input logic eob, input logic [63:0] body);
      resp_msg_t m;
      m.pkt_type      = {cls, 1'b1, eob};
      m.sid           = {i_sid[15:0], i_sid[31:16]};
      m.body          = body;
      exp_mem[wr_idx] = m;
      wr_idx++;
   endtask

   task automatic send_event(input logic is_err);
      i_sid        = 32'(rand_bits(32));
      i_error_code = rand_bits(64);
      i_ack        = ~is_err;
      i_error      = is_err;
      expect_msg(is_err ? MSG_ERR : MSG_FC, 1'b1, i_error_code);
      next_cycle();
      i_ack   = 1'b0;
      i_error = 1'b0;
   endtask

   task automatic consume_packet(input logic [11:0] seq);
      if (seq_model[11:0] == 12'hFFF)
         seq_model[31:12] = seq_model[31:12] + 20'd1;
      seq_model[11:0]   = seq;
      i_seqnum          = seq;
      i_packet_consumed = 1'b1;
      pkt_cnt++;
      if (pkt_cnt == FC_PKTS)
      begin
         pkt_cnt = 0;
         expect_msg(MSG_FC, 1'b0, {32'd0, seq_model});
      end
      next_cycle();
      i_packet_consumed = 1'b0;
      next_cycle();   // Trigger lands here.
   endtask

   task automatic wait_drain();
      while (wr_idx != rd_idx || o_tvalid)
         next_cycle();
   endtask

   always_comb
   begin
      case (word_idx)
         0:       exp_word = {exp_mem[rd_idx].pkt_type, exp_rseq, PKT_LEN, exp_mem[rd_idx].sid};
         1:       exp_word = exp_time;
         default: exp_word = exp_mem[rd_idx].body;
      endcase
   end

   always @(posedge clk)
   begin
      stall_q    <= i_rst_n && o_tvalid && !i_tready;
      held_tdata <= o_tdata;
      if (i_rst_n && o_tvalid && i_tready)
      begin
         if (word_idx == 0)
            exp_time <= i_vita_time;
         if (word_idx == LAST_IDX)
         begin
            word_idx <= 0;
            exp_rseq <= exp_rseq + 12'd1;
            rd_idx   <= rd_idx + 1;
         end
         else
            word_idx <= word_idx + 1;
      end
   end

   a_word: assert property (@(posedge clk) disable iff (!i_rst_n)
      (o_tvalid && i_tready) |-> (o_tdata == exp_word))
      else stop_on_error($sformatf("CHECK FAILED o_tdata got %h expected %h",
                                   $sampled(o_tdata), $sampled(exp_word)));

   a_last: assert property (@(posedge clk) disable iff (!i_rst_n)
      (o_tvalid && i_tready) |-> (o_tlast == (word_idx == LAST_IDX)))
      else stop_on_error($sformatf("CHECK FAILED o_tlast got %h expected %h",
                                   $sampled(o_tlast), $sampled(word_idx == LAST_IDX)));

   a_pending: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_tvalid |-> (wr_idx != rd_idx))
      else stop_on_error("The DUT sent a packet while no event was pending");

   a_stall: assert property (@(posedge clk) disable iff (!i_rst_n)
      stall_q |-> (o_tvalid && o_tdata == held_tdata))
      else stop_on_error($sformatf("CHECK FAILED o_tdata held %h now %h o_tvalid %h",
                                   $sampled(held_tdata), $sampled(o_tdata),
                                   $sampled(o_tvalid)));

   initial
   begin
      repeat (RESET_CYCLES + NUM_EVENTS * 40) @(posedge clk);
      stop_on_error("Timeout: the packets did not all come out in time");
   end

   initial
   begin
      logic [11:0] seq;
      repeat (RESET_CYCLES) @(negedge clk);
      i_rst_n = 1'b1;
      next_cycle();
      repeat (2)
      begin
         send_event(1'b0);
         wait_drain();
      end
      repeat (2)
      begin
         send_event(1'b1);
         wait_drain();
      end
      // Flow control ack every FC_PKTS packets.
      i_set = '{stb: 1'b1, addr: SR_FC_PKTS_ADDR, data: {1'b1, 31'(FC_PKTS)}};
      next_cycle();
      i_set.stb = 1'b0;
      seq = 12'h100 + 12'(rand_bits(8));
      repeat (2 * FC_PKTS)
      begin
         seq = seq + 12'(rand_bits(2)) + 12'd1;
         consume_packet(seq);
      end
      wait_drain();
      seq = 12'hFFC;   // Straight through the wrap.
      repeat (2 * FC_PKTS)
      begin
         consume_packet(seq);
         seq = seq + 12'd1;
      end
      wait_drain();
      rand_ready = 1'b1;
      repeat (8)
         send_event(rand_bits(1) != '0);
      repeat (FC_PKTS)
      begin
         seq = seq + 12'(rand_bits(2)) + 12'd1;
         consume_packet(seq);
      end
      wait_drain();
      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/tx_resp_pkg.sv
hw/fc_ack_trigger.sv
hw/resp_msg_fifo.sv
hw/context_pkt_gen.sv
hw/tx_responder.sv
verif/tb_tx_responder.sv

// ==== Makefile ====
SRCS := $(shell cat tb.f)

.PHONY: run clean

run: obj_dir/Vtb_tx_responder
	@out="$$(./obj_dir/Vtb_tx_responder)"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

obj_dir/Vtb_tx_responder: tb.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_tx_responder \
		-f tb.f -o Vtb_tx_responder

clean:
	rm -rf obj_dir
